// ==== flist.f ====
hw/conv_pkg.sv
hw/conv_fsm.sv
hw/conv_counters.sv
hw/weight_buffer.sv
hw/line_buffer.sv
hw/mac_pe.sv
hw/conv_top.sv
dv/tb_conv_top.sv

// ==== Bender.yml ====
package:
  name: conv_engine

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/conv_fsm.sv
      - hw/conv_counters.sv
      - hw/weight_buffer.sv
      - hw/line_buffer.sv
      - hw/mac_pe.sv
      - hw/conv_top.sv
  - target: simulation
    files:
      - dv/tb_conv_top.sv

// ==== dv/tb_conv_top.sv ====
`timescale 1ns/1ns

module tb_conv_top import conv_pkg::*; ();

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_RUNS       = 2;
    localparam int CYCLES_PER_RUN = 2000;                  // Generous bound for one image
    localparam int NUM_PIX        = PIC_SIZE * PIC_SIZE;
    localparam int FIRST_REQ      = (PAD + 1) * PIC_SIZE;  // Rows fetched for output row 0

    logic         clk = 1'b0;
    logic         rst_n;
    logic         conv_start;
    logic         pic_valid = 1'b0;
    pixel_t       pic = '0;
    weight_t      weight_data = '0;
    logic         weight_data_valid = 1'b0;
    logic         need_pic;
    logic         weight_addr_valid;
    weight_addr_t weight_addr;
    logic         conv_result_valid;
    result_t      conv_result;
    res_addr_t    conv_result_addr;
    logic         conv_finish;

    pixel_t  img [NUM_PIX];          // Image of the current run
    weight_t wts [KERNEL_TAPS];      // Weight memory contents
    result_t exp_q [$];              // Expected results in raster order
    int      seed = 32'h7bf6_194a;
    int      run_idx = 0;
    int      pix_cnt = 0;            // Pixels accepted this run
    int      waddr_cnt = 0;          // Weight strobes seen this run
    int      res_cnt = 0;            // Results seen this run
    logic    finish_seen = 1'b0;

    conv_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic halt_failed();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        halt_failed();
    endtask

    task automatic check_result(string name, result_t exp, result_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            halt_failed();
        end
    endtask

    task automatic check_addr(string name, res_addr_t exp, res_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            halt_failed();
        end
    endtask

    task automatic check_weight_addr(string name, weight_addr_t exp, weight_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            halt_failed();
        end
    endtask

    // Same-size 5x5 convolution where taps outside the image read as zero
    function automatic result_t ref_conv(int addr);
        int r;
        int c;
        int y;
        int x;
        int acc;
        r   = addr / PIC_SIZE;
        c   = addr % PIC_SIZE;
        acc = 0;
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                y = r + i - PAD;
                x = c + j - PAD;
                if (y >= 0 && y < PIC_SIZE && x >= 0 && x < PIC_SIZE) begin
                    acc += int'(img[y*PIC_SIZE + x]) * int'(wts[i*KERNEL_SIZE + j]);
                end
            end
        end
        return result_t'(acc);
    endfunction

    task automatic prepare_run();
        for (int i = 0; i < NUM_PIX; i++) img[i] = pixel_t'($random(seed));
        for (int k = 0; k < KERNEL_TAPS; k++) wts[k] = weight_t'($random(seed));
        exp_q.delete();
        for (int a = 0; a < NUM_PIX; a++) exp_q.push_back(ref_conv(a));
    endtask

    task automatic wait_finish();
        do @(posedge clk); while (conv_finish !== 1'b1);
    endtask

    // Weight memory answers every strobe one cycle later
    always @(posedge clk) begin
        weight_data_valid <= weight_addr_valid;
        if (weight_addr_valid) weight_data <= wts[weight_addr];
    end

    // Host model with random gaps that never drives past the end of a request
    always @(posedge clk) begin : drive_pixels
        logic accepted;
        logic req_end;
        accepted = pic_valid && need_pic;
        if (conv_start) pix_cnt = 0;
        else if (accepted) pix_cnt = pix_cnt + 1;
        req_end = accepted && pix_cnt >= FIRST_REQ && (pix_cnt - FIRST_REQ) % PIC_SIZE == 0;
        if (need_pic && !req_end && pix_cnt < NUM_PIX && ($random(seed) & 15) != 0) begin
            pic_valid <= 1'b1;
            pic       <= img[pix_cnt];
        end else begin
            pic_valid <= 1'b0;  // Gap or request complete
        end
    end

    always @(posedge clk) begin : compare_outputs
        result_t exp_res;
        if (conv_start) begin
            res_cnt     = 0;
            waddr_cnt   = 0;
            finish_seen = 1'b0;
        end
        if (weight_addr_valid) begin
            if (waddr_cnt >= KERNEL_TAPS) report_error("more than 25 weight strobes in one run");
            check_weight_addr($sformatf("run %0d weight strobe %0d", run_idx, waddr_cnt),
                              weight_addr_t'(waddr_cnt), weight_addr);
            waddr_cnt++;
        end
        if (conv_result_valid) begin
            if (exp_q.size() == 0) report_error("result arrived with no expected value left");
            exp_res = exp_q.pop_front();
            check_addr($sformatf("run %0d result address %0d", run_idx, res_cnt),
                       res_addr_t'(res_cnt), conv_result_addr);
            check_result($sformatf("run %0d result %0d", run_idx, res_cnt), exp_res, conv_result);
            res_cnt++;
        end
        if (conv_finish) begin
            if (finish_seen) report_error("conv_finish pulsed twice in one run");
            if (res_cnt != NUM_PIX) report_error("conv_finish came before all 784 results");
            if (pix_cnt != NUM_PIX) report_error("pixel count per run is not 784");
            if (waddr_cnt != KERNEL_TAPS) report_error("weight strobe count per run is not 25");
            finish_seen = 1'b1;
        end
    end

    initial begin
        repeat (NUM_RUNS * CYCLES_PER_RUN) @(posedge clk);
        report_error("timeout: run did not finish");
    end

    initial begin
        rst_n      = 1'b0;
        conv_start = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin                    // Idle outputs before any start
            @(posedge clk);
            if (need_pic !== 1'b0 || weight_addr_valid !== 1'b0 ||
                conv_result_valid !== 1'b0 || conv_finish !== 1'b0) begin
                report_error("an output was active before conv_start");
            end
        end
        for (int run = 0; run < NUM_RUNS; run++) begin
            run_idx = run;
            prepare_run();
            conv_start <= 1'b1;             // Second run starts right after the finish pulse
            @(posedge clk);
            conv_start <= 1'b0;
            wait_finish();
        end
        repeat (10) @(posedge clk);         // Catch stray results or pulses
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== hw/conv_top.sv ====
`timescale 1ns/1ns

module conv_top import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         conv_start,
    input  logic         pic_valid,
    input  pixel_t       pic,
    input  weight_t      weight_data,
    input  logic         weight_data_valid,
    output logic         need_pic,
    output logic         weight_addr_valid,
    output weight_addr_t weight_addr,
    output logic         conv_result_valid,
    output result_t      conv_result,
    output res_addr_t    conv_result_addr,
    output logic         conv_finish
);

    logic     w_start;
    logic     row_load;
    logic     row_first;
    logic     row_zero;
    logic     sweep_en;
    logic     drain_start;
    logic     run_clear;
    logic     w_done;
    logic     row_done;
    logic     col_last;
    logic     row_last;
    logic     drain_done;
    col_idx_t col_idx;       // Window start column
    window_t  window;
    logic     window_valid;
    kernel_t  kernel;

    conv_fsm u_fsm (
        .clk, .rst_n, .conv_start, .w_done, .row_done, .col_last, .row_last, .drain_done,
        .w_start, .row_load, .row_first, .row_zero, .sweep_en, .drain_start, .run_clear,
        .conv_finish
    );

    conv_counters u_counters (
        .clk, .rst_n, .run_clear, .sweep_en, .drain_start,
        .result_valid     (conv_result_valid),   // Address steps with each result
        .col_idx, .col_last, .row_last, .drain_done, .conv_result_addr
    );

    weight_buffer u_weights (
        .clk, .rst_n, .w_start, .weight_data, .weight_data_valid,
        .weight_addr, .weight_addr_valid, .w_done, .kernel
    );

    line_buffer u_lines (
        .clk, .rst_n, .row_load, .row_first, .row_zero, .pic_valid, .pic, .col_idx,
        .sweep_en, .need_pic, .row_done, .window, .window_valid
    );

    mac_pe u_mac (
        .clk, .rst_n,
        .in_valid     (window_valid),
        .window, .kernel,
        .result_valid (conv_result_valid),
        .result       (conv_result)
    );

endmodule

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ns

module mac_pe import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  window_t window,
    input  kernel_t kernel,
    output logic    result_valid,
    output result_t result
);

    result_t prod_q [KERNEL_TAPS];   // Stage 1 products
    result_t sum_c;                  // Adder tree input to stage 2
    logic    prod_valid;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                prod_q[i] <= $signed({1'b0, window[i]}) * kernel[i];   // Pixel is unsigned
            end
        end
    end

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            sum_c = sum_c + prod_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) result <= sum_c;   // Stage 2
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_valid   <= in_valid;      // Valid follows the data
            result_valid <= prod_valid;
        end
    end

endmodule

// ==== hw/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     row_load,
    input  logic     row_first,
    input  logic     row_zero,
    input  logic     pic_valid,
    input  pixel_t   pic,
    input  col_idx_t col_idx,
    input  logic     sweep_en,
    output logic     need_pic,
    output logic     row_done,
    output window_t  window,
    output logic     window_valid
);

    localparam int ROW_W = $clog2(KERNEL_SIZE);

    pixel_t           rows [KERNEL_SIZE][BUF_WIDTH];   // Row 0 is the top of the window
    logic [ROW_W-1:0] wr_row;                          // Row receiving pixels
    col_idx_t         wr_col;                          // Image column of next pixel
    logic             take;

    assign take = pic_valid && need_pic;   // Accepted pixel

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            need_pic <= 1'b0;
            row_done <= 1'b0;
            wr_row   <= '0;
            wr_col   <= '0;
        end else begin
            row_done <= 1'b0;
            if (row_load) begin
                wr_col <= '0;
                if (row_zero) begin
                    row_done <= 1'b1;      // Zero row needs no host data
                end else begin
                    need_pic <= 1'b1;
                    wr_row   <= row_first ? ROW_W'(PAD) : ROW_W'(KERNEL_SIZE - 1);
                end
            end else if (take) begin
                if (wr_col == col_idx_t'(PIC_SIZE - 1)) begin
                    wr_col <= '0;
                    if (wr_row == ROW_W'(KERNEL_SIZE - 1)) begin
                        need_pic <= 1'b0;  // Drops right after the last pixel
                        row_done <= 1'b1;
                    end else begin
                        wr_row <= wr_row + 1'b1;
                    end
                end else begin
                    wr_col <= wr_col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_load) begin
            for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                for (int c = 0; c < BUF_WIDTH; c++) begin
                    rows[r][c] <= row_first ? '0 : rows[r+1][c];   // Clear or shift up
                end
            end
            for (int c = 0; c < BUF_WIDTH; c++) begin
                rows[KERNEL_SIZE-1][c] <= '0;   // Fresh bottom row, padding stays zero
            end
        end else if (take) begin
            rows[wr_row][PAD + wr_col] <= pic;
        end
    end

    // Window register doubles as the MAC input stage
    always_ff @(posedge clk) begin
        if (sweep_en) begin
            for (int i = 0; i < KERNEL_SIZE; i++) begin
                for (int j = 0; j < KERNEL_SIZE; j++) begin
                    window[i*KERNEL_SIZE + j] <= rows[i][col_idx + j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) window_valid <= 1'b0;
        else        window_valid <= sweep_en;   // Tracks the window register
    end

    // Host may only present pixels while a row is being requested
    assert property (@(posedge clk) disable iff (!rst_n) pic_valid |-> need_pic)
        else $error("pic_valid without need_pic");

endmodule

// ==== hw/weight_buffer.sv ====
`timescale 1ns/1ns

module weight_buffer import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         w_start,
    input  weight_t      weight_data,
    input  logic         weight_data_valid,
    output weight_addr_t weight_addr,
    output logic         weight_addr_valid,
    output logic         w_done,
    output kernel_t      kernel
);

    localparam weight_addr_t LAST_TAP = weight_addr_t'(KERNEL_TAPS - 1);

    weight_addr_t issue_cnt;    // Next address to strobe
    weight_addr_t rx_cnt;       // Tap for the next returned weight
    logic         issue_busy;

    assign weight_addr       = issue_cnt;
    assign weight_addr_valid = issue_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_busy <= 1'b0;
            issue_cnt  <= '0;
            rx_cnt     <= '0;
            w_done     <= 1'b0;
        end else begin
            w_done <= 1'b0;
            if (w_start) begin
                issue_busy <= 1'b1;
                issue_cnt  <= '0;
            end else if (issue_busy) begin
                issue_cnt <= issue_cnt + 1'b1;   // Back-to-back strobes
                if (issue_cnt == LAST_TAP) issue_busy <= 1'b0;
            end
            if (w_start) begin
                rx_cnt <= '0;
            end else if (weight_data_valid) begin
                rx_cnt <= rx_cnt + 1'b1;
                if (rx_cnt == LAST_TAP) w_done <= 1'b1;   // Kernel complete
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weight_data_valid) kernel[rx_cnt] <= weight_data;   // Replies come in order
    end

endmodule

// ==== hw/conv_counters.sv ====
`timescale 1ns/1ns

module conv_counters import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run_clear,
    input  logic      sweep_en,
    input  logic      drain_start,
    input  logic      result_valid,
    output col_idx_t  col_idx,
    output logic      col_last,
    output logic      row_last,
    output logic      drain_done,
    output res_addr_t conv_result_addr
);

    localparam int DRAIN_W = $clog2(MAC_LAT + 1);

    row_idx_t           row_idx;     // Output row being swept
    logic [DRAIN_W-1:0] drain_cnt;   // Cycles left in DRAIN

    assign col_last   = (col_idx == col_idx_t'(PIC_SIZE - 1));
    assign row_last   = (row_idx == row_idx_t'(PIC_SIZE - PAD));  // Next row needs no pixels
    assign drain_done = (drain_cnt == DRAIN_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_idx          <= '0;
            row_idx          <= '0;
            drain_cnt        <= '0;
            conv_result_addr <= '0;
        end else begin
            if (run_clear) begin
                col_idx <= '0;
                row_idx <= '0;
            end else if (sweep_en) begin
                col_idx <= col_last ? '0 : col_idx + 1'b1;   // One window per cycle
                if (col_last) begin
                    row_idx <= (row_idx == row_idx_t'(PIC_SIZE - 1)) ? '0 : row_idx + 1'b1;
                end
            end
            if (drain_start) begin
                drain_cnt <= DRAIN_W'(MAC_LAT);   // Wait out the MAC pipeline
            end else if (drain_cnt != '0) begin
                drain_cnt <= drain_cnt - 1'b1;
            end
            if (run_clear) begin
                conv_result_addr <= '0;
            end else if (result_valid) begin
                conv_result_addr <= conv_result_addr + 1'b1;  // Raster order
            end
        end
    end

endmodule

// ==== hw/conv_fsm.sv ====
`timescale 1ns/1ns

module conv_fsm import conv_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic conv_start,
    input  logic w_done,
    input  logic row_done,
    input  logic col_last,
    input  logic row_last,
    input  logic drain_done,
    output logic w_start,
    output logic row_load,
    output logic row_first,
    output logic row_zero,
    output logic sweep_en,
    output logic drain_start,
    output logic run_clear,
    output logic conv_finish
);

    conv_state_t state;
    logic        first_q;   // Next load is output row 0
    logic        zero_a;    // Next load is output row 26
    logic        zero_b;    // Next load is output row 27

    assign row_first = first_q;            // Qualified by row_load
    assign row_zero  = zero_a | zero_b;    // Bottom padding rows

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            w_start     <= 1'b0;
            row_load    <= 1'b0;
            sweep_en    <= 1'b0;
            drain_start <= 1'b0;
            run_clear   <= 1'b0;
            conv_finish <= 1'b0;
            first_q     <= 1'b0;
            zero_a      <= 1'b0;
            zero_b      <= 1'b0;
        end else begin
            w_start     <= 1'b0;   // One-cycle commands
            row_load    <= 1'b0;
            drain_start <= 1'b0;
            run_clear   <= 1'b0;
            conv_finish <= 1'b0;
            case (state)
                IDLE: begin
                    if (conv_start) begin
                        state     <= LOAD_W;
                        w_start   <= 1'b1;   // Kick off kernel fetch
                        run_clear <= 1'b1;   // Reset counters for a new image
                        first_q   <= 1'b1;
                        zero_a    <= 1'b0;
                        zero_b    <= 1'b0;
                    end
                end
                LOAD_W: begin
                    if (w_done) begin
                        state    <= LOAD_ROW;
                        row_load <= 1'b1;    // First three image rows
                    end
                end
                LOAD_ROW: begin
                    if (row_done) begin
                        state    <= CAL;
                        sweep_en <= 1'b1;    // Held for the whole sweep
                    end
                end
                CAL: begin
                    if (col_last) begin
                        state       <= DRAIN;
                        sweep_en    <= 1'b0;
                        drain_start <= 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_done) begin
                        if (zero_b) begin    // Row 27 just finished
                            state       <= IDLE;
                            conv_finish <= 1'b1;
                        end else begin
                            state    <= LOAD_ROW;
                            row_load <= 1'b1;
                            first_q  <= 1'b0;
                            zero_a   <= row_last;   // Image rows exhausted
                            zero_b   <= zero_a;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The window sweep must stay inside CAL, or partial rows reach the MAC
    assert property (@(posedge clk) disable iff (!rst_n) sweep_en |-> state == CAL)
        else $error("sweep_en high outside CAL");

endmodule

// ==== hw/conv_pkg.sv ====
package conv_pkg;

    localparam int PIC_SIZE    = 28;                       // Image width and height
    localparam int KERNEL_SIZE = 5;                        // Kernel side
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE; // Taps per window
    localparam int PAD         = KERNEL_SIZE / 2;          // Zero border on each side
    localparam int BUF_WIDTH   = PIC_SIZE + 2 * PAD;       // Padded row length
    localparam int PIXEL_BITS  = 8;
    localparam int WEIGHT_BITS = 8;
    localparam int RESULT_BITS = 21;                       // Holds 25 pixel x weight products
    localparam int MAC_LAT     = 2;                        // Window register to result

    typedef logic        [PIXEL_BITS-1:0]  pixel_t;        // Unsigned pixel
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;       // Signed weight
    typedef logic signed [RESULT_BITS-1:0] result_t;       // Full precision result

    typedef pixel_t  window_t [KERNEL_TAPS];               // Row-major 5x5 window
    typedef weight_t kernel_t [KERNEL_TAPS];               // Row-major 5x5 kernel

    typedef logic [$clog2(PIC_SIZE)-1:0]            col_idx_t;
    typedef logic [$clog2(PIC_SIZE)-1:0]            row_idx_t;
    typedef logic [$clog2(PIC_SIZE*PIC_SIZE)-1:0]   res_addr_t;    // Raster result address
    typedef logic [$clog2(KERNEL_TAPS)-1:0]         weight_addr_t;

    typedef enum logic [2:0] {
        IDLE,      // Waiting for conv_start
        LOAD_W,    // Kernel fetch
        LOAD_ROW,  // Line buffer update
        CAL,       // Window sweep over one output row
        DRAIN      // Pipeline flush
    } conv_state_t;

endpackage
